// ==== lsu_pkg.sv ====
// Load/store unit package with widths, size codes and the request and response structs
`default_nettype none

package lsu_pkg;

  ////////////////////////////////////////////////////////////
  // Widths and depths
  ////////////////////////////////////////////////////////////

  localparam int ADDR_W          = 32;
  localparam int DATA_W          = 32;
  localparam int BE_W            = 4;
  // Bus parts in flight at most
  localparam int MAX_OUTSTANDING = 2;
  // Occupancy count, holds 0 to MAX_OUTSTANDING
  localparam int CNT_W           = 2;

  ////////////////////////////////////////////////////////////
  // Encodings and structs
  ////////////////////////////////////////////////////////////

  // Access size, 2'b11 is unused
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'd0,
    SIZE_HALF = 2'd1,
    SIZE_WORD = 2'd2
  } lsu_size_e;

  // Request from the execute stage
  typedef struct packed {
    logic              we;
    lsu_size_e         size;
    logic              sext;
    logic [DATA_W-1:0] op_a;
    logic [DATA_W-1:0] op_b;
    logic [DATA_W-1:0] wdata;
  } lsu_req_t;

  // Result of one instruction
  typedef struct packed {
    logic [DATA_W-1:0] rdata;
    logic              err;
  } lsu_rsp_t;

  // Bus address phase
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic              we;
    logic [BE_W-1:0]   be;
    logic [DATA_W-1:0] wdata;
  } bus_req_t;

  // Bus response phase
  typedef struct packed {
    logic [DATA_W-1:0] rdata;
    logic              err;
  } bus_rsp_t;

  // Per-part control kept until its response
  typedef struct packed {
    lsu_size_e  size;
    logic       sext;
    logic       we;
    logic [1:0] offset;
    // Low only for the first half of a split
    logic       last;
  } txn_info_t;

endpackage

`default_nettype wire

// ==== lsu_request_gen.sv ====
// Request generator forming address, byte enables, rotated store data and split state per part
`default_nettype none
`timescale 1ns/100ps

module lsu_request_gen import lsu_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      valid_i,
  input  lsu_req_t  req_i,
  // Current part granted on the bus
  input  logic      part_done_i,
  output bus_req_t  bus_req_o,
  output logic      split_o,
  output txn_info_t info_o
);

  logic [ADDR_W-1:0] addr;
  logic [1:0]        offset;
  // Second address phase of a split access
  logic              second_q;
  logic [BE_W-1:0]   be;
  logic [DATA_W-1:0] wdata_rot;

  // Effective address
  assign addr   = req_i.op_a + req_i.op_b;
  assign offset = addr[1:0];

  ////////////////////////////////////////////////////////////
  // Byte enables
  ////////////////////////////////////////////////////////////

  always_comb begin
    be = 4'b0000;
    case (req_i.size)
      SIZE_BYTE: begin
        case (offset)
          2'b00: be = 4'b0001;
          2'b01: be = 4'b0010;
          2'b10: be = 4'b0100;
          default: be = 4'b1000;
        endcase
      end
      SIZE_HALF: begin
        if (!second_q) begin
          case (offset)
            2'b00: be = 4'b0011;
            2'b01: be = 4'b0110;
            2'b10: be = 4'b1100;
            default: be = 4'b1000;
          endcase
        end else begin
          // Upper byte spills into the next word
          be = 4'b0001;
        end
      end
      default: begin
        if (!second_q) begin
          case (offset)
            2'b00: be = 4'b1111;
            2'b01: be = 4'b1110;
            2'b10: be = 4'b1100;
            default: be = 4'b1000;
          endcase
        end else begin
          // Offset 0 never reaches a second phase
          case (offset)
            2'b00: be = 4'b0000;
            2'b01: be = 4'b0001;
            2'b10: be = 4'b0011;
            default: be = 4'b0111;
          endcase
        end
      end
    endcase
  end

  // Rotate store data left by the byte offset, same lanes serve both phases
  always_comb begin
    case (offset)
      2'b00: wdata_rot = req_i.wdata;
      2'b01: wdata_rot = {req_i.wdata[23:0], req_i.wdata[31:24]};
      2'b10: wdata_rot = {req_i.wdata[15:0], req_i.wdata[31:16]};
      default: wdata_rot = {req_i.wdata[7:0], req_i.wdata[31:8]};
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Split detection and phase tracking
  ////////////////////////////////////////////////////////////

  // Word off alignment, or halfword at offset 3, in the first phase only
  always_comb begin
    split_o = 1'b0;
    if (valid_i && !second_q) begin
      case (req_i.size)
        SIZE_WORD: split_o = (offset != 2'b00);
        SIZE_HALF: split_o = (offset == 2'b11);
        default:   split_o = 1'b0;
      endcase
    end
  end

  // Set on the first grant of a split, cleared on the next grant
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      second_q <= 1'b0;
    end else if (!valid_i) begin
      second_q <= 1'b0;
    end else if (part_done_i) begin
      second_q <= split_o;
    end
  end

  // Second phase goes to the next word up
  assign bus_req_o.addr  = second_q ? ({addr[ADDR_W-1:2], 2'b00} + ADDR_W'(4)) : addr;
  assign bus_req_o.we    = req_i.we;
  assign bus_req_o.be    = be;
  assign bus_req_o.wdata = wdata_rot;

  // Control for the tracker
  assign info_o.size   = req_i.size;
  assign info_o.sext   = req_i.sext;
  assign info_o.we     = req_i.we;
  assign info_o.offset = offset;
  assign info_o.last   = !split_o;

endmodule

`default_nettype wire

// ==== lsu_txn_tracker.sv ====
// In-order tracker of outstanding bus parts with issue control, ready and busy
`default_nettype none
`timescale 1ns/100ps

module lsu_txn_tracker import lsu_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      valid_i,
  // Current part is the first half of a split
  input  logic      split_i,
  input  txn_info_t info_i,
  input  logic      gnt_i,
  input  logic      rvalid_i,
  output logic      req_valid_o,
  output logic      part_done_o,
  output logic      ready_o,
  output logic      busy_o,
  output txn_info_t head_o
);

  // Entry storage
  txn_info_t          fifo_q [MAX_OUTSTANDING];
  logic [CNT_W-2:0]   wr_ptr_q;
  logic [CNT_W-2:0]   rd_ptr_q;
  logic [CNT_W-1:0]   cnt_q;
  logic [CNT_W-1:0]   cnt_next;
  logic               push;
  logic               pop;

  ////////////////////////////////////////////////////////////
  // Issue control
  ////////////////////////////////////////////////////////////

  // Hold the address phase back once the tracker is full
  assign req_valid_o = valid_i && (cnt_q < MAX_OUTSTANDING);
  assign part_done_o = req_valid_o && gnt_i;

  // First grant of a split keeps the instruction in place
  assign ready_o = !valid_i || (part_done_o && !split_i);

  assign busy_o = (cnt_q != '0) || req_valid_o;

  // Grant pushes and response pops, possibly in the same cycle
  assign push = part_done_o;
  assign pop  = rvalid_i;

  ////////////////////////////////////////////////////////////
  // Occupancy count
  ////////////////////////////////////////////////////////////

  always_comb begin
    case ({push, pop})
      2'b10:   cnt_next = cnt_q + 1'b1;
      2'b01:   cnt_next = cnt_q - 1'b1;
      default: cnt_next = cnt_q;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_next;
    end
  end

  ////////////////////////////////////////////////////////////
  // Entry FIFO
  ////////////////////////////////////////////////////////////

  // Pointers wrap naturally at depth 2
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      fifo_q[wr_ptr_q] <= info_i;
    end
  end

  // Oldest part in flight belongs to the next response
  assign head_o = fifo_q[rd_ptr_q];

endmodule

`default_nettype wire

// ==== lsu_rdata_align.sv ====
// Load data realignment, split join, sign extension and error merge
`default_nettype none
`timescale 1ns/100ps

module lsu_rdata_align import lsu_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      rvalid_i,
  input  bus_rsp_t  rsp_i,
  // Control of the part this response belongs to
  input  txn_info_t head_i,
  output logic      rsp_valid_o,
  output lsu_rsp_t  rsp_o
);

  // Raw first-half data of a split load
  logic [DATA_W-1:0]   rdata_q;
  // First-half error of a split access
  logic                err_q;
  logic                is_split;
  logic [2*DATA_W-1:0] rdata_full;
  logic [DATA_W-1:0]   rdata_aligned;
  logic [DATA_W-1:0]   rdata_ext;

  ////////////////////////////////////////////////////////////
  // First-half capture
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rvalid_i && !head_i.last && !head_i.we) begin
      rdata_q <= rsp_i.rdata;
    end
  end

  // Error held across the two halves, cleared by the last one
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      err_q <= 1'b0;
    end else if (rvalid_i) begin
      err_q <= head_i.last ? 1'b0 : rsp_i.err;
    end
  end

  ////////////////////////////////////////////////////////////
  // Realign and extend
  ////////////////////////////////////////////////////////////

  assign is_split = ((head_i.size == SIZE_WORD) && (head_i.offset != 2'b00)) ||
                    ((head_i.size == SIZE_HALF) && (head_i.offset == 2'b11));

  // Self copy lets upper lanes wrap into the low bytes
  assign rdata_full = is_split ? {rsp_i.rdata, rdata_q} : {rsp_i.rdata, rsp_i.rdata};

  // Shift right by 8 times the offset
  assign rdata_aligned = DATA_W'(rdata_full >> {head_i.offset, 3'b000});

  always_comb begin
    case (head_i.size)
      SIZE_BYTE: rdata_ext = {{24{head_i.sext && rdata_aligned[7]}}, rdata_aligned[7:0]};
      SIZE_HALF: rdata_ext = {{16{head_i.sext && rdata_aligned[15]}}, rdata_aligned[15:0]};
      default:   rdata_ext = rdata_aligned;
    endcase
  end

  // One pulse per instruction, on its last part
  assign rsp_valid_o = rvalid_i && head_i.last;
  assign rsp_o.rdata = rdata_ext;
  assign rsp_o.err   = rsp_i.err || err_q;

endmodule

`default_nettype wire

// ==== lsu_top.sv ====
// Load/store unit top connecting request generation, tracking and load alignment
`default_nettype none
`timescale 1ns/100ps

module lsu_top import lsu_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  // Execute side
  input  logic     lsu_valid_i,
  input  lsu_req_t lsu_req_i,
  output logic     lsu_ready_o,
  // Bus side
  output logic     data_req_valid_o,
  output bus_req_t data_req_o,
  input  logic     data_gnt_i,
  input  logic     data_rvalid_i,
  input  bus_rsp_t data_rsp_i,
  // Write-back side
  output logic     lsu_rsp_valid_o,
  output lsu_rsp_t lsu_rsp_o,
  output logic     busy_o
);

  logic      split;
  logic      part_done;
  txn_info_t info;
  txn_info_t head;

  ////////////////////////////////////////////////////////////
  // Address phase
  ////////////////////////////////////////////////////////////

  lsu_request_gen i_request_gen (
    .clk         (clk),
    .rst_n       (rst_n),
    .valid_i     (lsu_valid_i),
    .req_i       (lsu_req_i),
    .part_done_i (part_done),
    .bus_req_o   (data_req_o),
    .split_o     (split),
    .info_o      (info)
  );

  lsu_txn_tracker i_txn_tracker (
    .clk         (clk),
    .rst_n       (rst_n),
    .valid_i     (lsu_valid_i),
    .split_i     (split),
    .info_i      (info),
    .gnt_i       (data_gnt_i),
    .rvalid_i    (data_rvalid_i),
    .req_valid_o (data_req_valid_o),
    .part_done_o (part_done),
    .ready_o     (lsu_ready_o),
    .busy_o      (busy_o),
    .head_o      (head)
  );

  ////////////////////////////////////////////////////////////
  // Response phase
  ////////////////////////////////////////////////////////////

  lsu_rdata_align i_rdata_align (
    .clk         (clk),
    .rst_n       (rst_n),
    .rvalid_i    (data_rvalid_i),
    .rsp_i       (data_rsp_i),
    .head_i      (head),
    .rsp_valid_o (lsu_rsp_valid_o),
    .rsp_o       (lsu_rsp_o)
  );

endmodule

`default_nettype wire

// ==== tb_lsu_mem_model.sv ====
// Bus-side memory model with random grant, in-order delayed responses and an error region
`default_nettype none
`timescale 1ns/100ps

module tb_lsu_mem_model import lsu_pkg::*; #(
  parameter int SEED = 0
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     req_valid_i,
  input  bus_req_t req_i,
  output logic     gnt_o,
  output logic     rvalid_o,
  output bus_rsp_t rsp_o
);

  logic [7:0] mem [256];
  bus_rsp_t   rsp_q [$];
  // Cycle in which each queued response may go out
  int         due_q [$];
  int         cycle;
  int         due;
  int         last_due;
  integer     seed;
  bus_rsp_t   rsp;

  initial begin
    seed     = SEED;
    cycle    = 0;
    last_due = 0;
    gnt_o    = 1'b0;
    rvalid_o = 1'b0;
    rsp_o    = '0;
    // Fill pattern covers all 256 byte addresses
    for (int i = 0; i < 256; i++)
      mem[i] = 8'(i * 7 + 8'h3c);
  end

  // Address phase taken mid-cycle, away from the clock edge
  always @(negedge clk) begin
    if (rst_n && req_valid_i && gnt_o) begin
      for (int b = 0; b < BE_W; b++) begin
        if (req_i.we && req_i.be[b])
          mem[{req_i.addr[7:2], 2'(b)}] = req_i.wdata[8*b +: 8];
        rsp.rdata[8*b +: 8] = mem[{req_i.addr[7:2], 2'(b)}];
      end
      // Top quarter of the array answers with an error
      rsp.err = req_i.addr[7] && req_i.addr[6];
      // 1 to 3 cycles later, never ahead of an older response
      due = cycle + 1 + {$random(seed)} % 3;
      if (due <= last_due)
        due = last_due + 1;
      last_due = due;
      rsp_q.push_back(rsp);
      due_q.push_back(due);
    end
  end

  // Grant and response change just after the rising edge
  always @(posedge clk) begin
    cycle = cycle + 1;
    #1;
    if (!rst_n) begin
      gnt_o    = 1'b0;
      rvalid_o = 1'b0;
      rsp_q.delete();
      due_q.delete();
    end else begin
      gnt_o = ({$random(seed)} % 3) != 0;
      if (due_q.size() > 0 && due_q[0] <= cycle) begin
        rvalid_o = 1'b1;
        rsp_o    = rsp_q.pop_front();
        void'(due_q.pop_front());
      end else begin
        rvalid_o = 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== tb_lsu.sv ====
// Testbench for the load/store unit checking random operations against a byte-level model
`default_nettype none
`timescale 1ns/100ps

module tb_lsu import lsu_pkg::*; ();

  localparam int N_OPS      = 400;
  // 20 cycles of 4 ns per operation
  localparam int TIMEOUT_NS = N_OPS * 20 * 4;

  logic        clk;
  logic        rst_n;
  logic        lsu_valid;
  lsu_req_t    lsu_req;
  logic        lsu_ready;
  logic        data_req_valid;
  bus_req_t    data_req;
  logic        data_gnt;
  logic        data_rvalid;
  bus_rsp_t    data_rsp;
  logic        lsu_rsp_valid;
  lsu_rsp_t    lsu_rsp;
  logic        busy;

  // Reference memory and expected results in order
  logic [7:0]  ref_mem [256];
  bus_req_t    exp_bus_q [$];
  lsu_rsp_t    exp_rsp_q [$];
  logic        exp_store_q [$];
  integer      seed;
  int          data_errs;
  int          proto_errs;
  int          outstanding;
  logic        req_pending;
  bus_req_t    held_req;
  lsu_req_t    req;
  logic [31:0] r;

  lsu_top i_dut (
    .clk              (clk),
    .rst_n            (rst_n),
    .lsu_valid_i      (lsu_valid),
    .lsu_req_i        (lsu_req),
    .lsu_ready_o      (lsu_ready),
    .data_req_valid_o (data_req_valid),
    .data_req_o       (data_req),
    .data_gnt_i       (data_gnt),
    .data_rvalid_i    (data_rvalid),
    .data_rsp_i       (data_rsp),
    .lsu_rsp_valid_o  (lsu_rsp_valid),
    .lsu_rsp_o        (lsu_rsp),
    .busy_o           (busy)
  );

  tb_lsu_mem_model #(.SEED(32'h1ec0_fdbd)) i_mem (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_valid_i (data_req_valid),
    .req_i       (data_req),
    .gnt_o       (data_gnt),
    .rvalid_o    (data_rvalid),
    .rsp_o       (data_rsp)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  ////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////

  task automatic check_bus_req(input bus_req_t exp, input bus_req_t act);
    if (act !== exp) begin
      data_errs++;
      $display("[ERROR] data_req_o: expected %h, actual %h", exp, act);
    end
  endtask

  // Stores carry no read data so only err is compared
  task automatic check_rsp(input lsu_rsp_t exp, input lsu_rsp_t act, input logic err_only);
    if (err_only && act.err !== exp.err) begin
      data_errs++;
      $display("[ERROR] lsu_rsp_o.err: expected %h, actual %h", exp.err, act.err);
    end else if (!err_only && act !== exp) begin
      data_errs++;
      $display("[ERROR] lsu_rsp_o: expected %h, actual %h", exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      data_errs++;
      $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Reference model and request driver
  ////////////////////////////////////////////////////////////

  task automatic issue_op(input lsu_req_t op);
    logic [31:0] addr;
    logic [31:0] next_word;
    logic [7:0]  mask;
    logic [63:0] wide;
    logic [31:0] val;
    int          nbytes;
    int          i;
    bus_req_t    part;
    lsu_rsp_t    rsp;
    addr   = op.op_a + op.op_b;
    nbytes = (op.size == SIZE_BYTE) ? 1 : (op.size == SIZE_HALF) ? 2 : 4;
    // Lanes 4 to 7 spill into the next word
    mask = 8'((1 << nbytes) - 1) << addr[1:0];
    wide = {op.wdata, op.wdata} << (8 * addr[1:0]);
    part = '{addr: addr, we: op.we, be: mask[3:0], wdata: wide[63:32]};
    exp_bus_q.push_back(part);
    rsp.err = addr[7] && addr[6];
    if (mask[7:4] != 4'b0000) begin
      next_word = {addr[31:2], 2'b00} + 32'd4;
      part.addr = next_word;
      part.be   = mask[7:4];
      exp_bus_q.push_back(part);
      rsp.err   = rsp.err || (next_word[7] && next_word[6]);
    end
    val = '0;
    for (i = 0; i < nbytes; i++) begin
      if (op.we)
        ref_mem[8'(addr + i)] = op.wdata[8*i +: 8];
      val[8*i +: 8] = ref_mem[8'(addr + i)];
    end
    if (nbytes == 1)
      val = {{24{op.sext && val[7]}}, val[7:0]};
    else if (nbytes == 2)
      val = {{16{op.sext && val[15]}}, val[15:0]};
    rsp.rdata = val;
    exp_rsp_q.push_back(rsp);
    exp_store_q.push_back(op.we);
    lsu_valid = 1'b1;
    lsu_req   = op;
    do @(negedge clk); while (!lsu_ready);
    @(posedge clk);
    #1;
    lsu_valid = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////
  // Bus and response monitor
  ////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    if (rst_n) begin
      if (req_pending && (data_req_valid !== 1'b1 || data_req !== held_req)) begin
        proto_errs++;
        $display("Address phase changed or dropped before its grant at %0t", $time);
      end
      req_pending = data_req_valid && !data_gnt;
      held_req    = data_req;
      // Busy and ready follow the handshakes seen so far
      check_flag("busy_o", (outstanding != 0) || lsu_valid, busy);
      check_flag("lsu_ready_o",
                 !lsu_valid || (data_req_valid && data_gnt && exp_bus_q.size() == 1),
                 lsu_ready);
      if (data_rvalid) begin
        if (outstanding == 0) begin
          proto_errs++;
          $display("Bus response with nothing outstanding at %0t", $time);
        end else begin
          outstanding--;
        end
      end
      if (data_req_valid && data_gnt) begin
        outstanding++;
        if (exp_bus_q.size() == 0) begin
          proto_errs++;
          $display("Bus request granted with none expected at %0t", $time);
        end else begin
          check_bus_req(exp_bus_q.pop_front(), data_req);
        end
      end
      if (outstanding > MAX_OUTSTANDING) begin
        proto_errs++;
        $display("More than %0d bus parts in flight at %0t", MAX_OUTSTANDING, $time);
      end
      if (lsu_rsp_valid) begin
        if (exp_rsp_q.size() == 0) begin
          proto_errs++;
          $display("Response pulse with no instruction pending at %0t", $time);
        end else begin
          check_rsp(exp_rsp_q.pop_front(), lsu_rsp, exp_store_q.pop_front());
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus and closing report
  ////////////////////////////////////////////////////////////

  initial begin
    seed        = 32'h1ec0_fdbd;
    data_errs   = 0;
    proto_errs  = 0;
    outstanding = 0;
    req_pending = 1'b0;
    rst_n       = 1'b0;
    lsu_valid   = 1'b0;
    lsu_req     = '0;
    req         = '0;
    for (int i = 0; i < 256; i++)
      ref_mem[i] = 8'(i * 7 + 8'h3c);
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;
    for (int n = 0; n < N_OPS; n++) begin
      r = $random(seed);
      // One in four loads back from the previous address
      if (r[1:0] == 2'b00) begin
        req.we = 1'b0;
      end else begin
        req.we   = r[2];
        req.op_a = $random(seed) & 32'hf0;
        // About 70 percent word-aligned
        if ({$random(seed)} % 10 < 7)
          req.op_b = $random(seed) & 32'h0c;
        else
          req.op_b = $random(seed) & 32'h0f;
      end
      req.size  = (r[4:3] == 2'd0) ? SIZE_BYTE : (r[4:3] == 2'd1) ? SIZE_HALF : SIZE_WORD;
      req.sext  = r[5];
      req.wdata = $random(seed);
      issue_op(req);
      // Occasional idle cycle
      if (r[8:6] == 3'd0) begin
        @(posedge clk);
        #1;
      end
    end
    while (exp_rsp_q.size() != 0)
      @(negedge clk);
    repeat (5) @(negedge clk);
    if (exp_bus_q.size() != 0 || outstanding != 0 || busy) begin
      proto_errs++;
      $display("Unit not idle at the end, %0d parts still expected", exp_bus_q.size());
    end
    $display("Errors: %0d data, %0d protocol", data_errs, proto_errs);
    if (data_errs + proto_errs == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

  // Watchdog
  initial begin
    #(TIMEOUT_NS);
    $display("Timeout, the run did not finish within %0d ns", TIMEOUT_NS);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

// ==== src.f ====
lsu_pkg.sv
lsu_request_gen.sv
lsu_txn_tracker.sv
lsu_rdata_align.sv
lsu_top.sv
tb_lsu_mem_model.sv
tb_lsu.sv
